// File: logic/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	// UART bit timing
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	// Mid-bit point of the start bit
	localparam logic [BIT_CNT_W-1:0] HALF_BIT = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// 8N1 frame: start, eight data bits, stop
	localparam int FRAME_BITS = 10;
	localparam int FRAME_IDX_W = $clog2(FRAME_BITS);
	localparam logic [FRAME_IDX_W-1:0] FRAME_LAST = FRAME_IDX_W'(FRAME_BITS - 1);

	// CPU reset pulse length
	localparam int RST_HOLD_CYCLES = 256;
	localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES);
	localparam logic [RST_CNT_W-1:0] RST_CNT_LAST = RST_CNT_W'(RST_HOLD_CYCLES - 1);

	// Shared RAM size
	localparam int RAM_DEPTH = 256;
	localparam int RAM_AW = $clog2(RAM_DEPTH);

	// Host command opcodes
	typedef enum logic [7:0] {
		CMD_HALT   = 8'h00,
		CMD_RESUME = 8'h01,
		CMD_WRITE  = 8'h02,
		CMD_READ   = 8'h03,
		CMD_RESET  = 8'h04
	} cmd_e;

	// Control FSM states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_RD_ADDR_H,
		ST_RD_ADDR_L,
		ST_RD_WAIT,
		ST_RD_SEND,
		ST_WR_ADDR_H,
		ST_WR_ADDR_L,
		ST_WR_DATA,
		ST_RST_HOLD
	} ctrl_state_e;

	// One memory bus request
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
		logic        re;
	} bus_req_t;

endpackage

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx import dbg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rxd,
	output logic rx_valid,
	output logic [7:0] rx_data
);

	// Two-flop synchronizer on the serial line
	logic rx_meta;
	logic rx_s;

	// Frame tracking
	logic busy;
	logic [BIT_CNT_W-1:0] clk_cnt;
	// 0 is start, 1 to 8 are data, 9 is stop
	logic [FRAME_IDX_W-1:0] bit_idx;
	logic [7:0] shreg;

	// Start bit is sampled at half a bit, the rest a full bit apart
	logic sample;

	assign sample = (bit_idx == '0) ? (clk_cnt == HALF_BIT) : (clk_cnt == BIT_LAST);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			// Line idles high
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_s <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			shreg <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!busy) begin
				// Falling edge opens a frame
				if (!rx_s) begin
					busy <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				if (bit_idx == '0) begin
					// Glitch, start bit gone by mid-bit
					if (rx_s)
						busy <= 1'b0;
					else
						bit_idx <= bit_idx + 1'b1;
				end else if (bit_idx == FRAME_LAST) begin
					// Stop bit reached, byte complete
					rx_valid <= 1'b1;
					busy <= 1'b0;
				end else begin
					// Data arrives LSB first
					shreg <= {rx_s, shreg[7:1]};
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// Holds until the next frame's data bits
	assign rx_data = shreg;

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx import dbg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic tx_start,
	input logic [7:0] tx_data,
	output logic txd,
	output logic tx_done
);

	// Whole frame, shifted out from bit 0
	logic [FRAME_BITS-1:0] shreg;
	logic busy;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [FRAME_IDX_W-1:0] bit_idx;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			shreg <= '1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				// Stop, data, start
				shreg <= {1'b1, tx_data, 1'b0};
				busy <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == BIT_LAST) begin
			clk_cnt <= '0;
			// Fill with idle level behind the frame
			shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
			if (bit_idx == FRAME_LAST)
				busy <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Idle line is high
	assign txd = busy ? shreg[0] : 1'b1;
	// Done drops the cycle after start, rises after the stop bit
	assign tx_done = !busy;

	// The control FSM must wait for an idle transmitter
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst)
		tx_start |-> tx_done);

endmodule

`default_nettype wire

// File: logic/sys_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module sys_ctrl_fsm import dbg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input logic [7:0] rx_data,
	input logic tx_done,
	output logic tx_start,
	output logic [7:0] tx_data,
	input logic [7:0] rdata,
	output bus_req_t mon_req,
	output logic cpu_halt,
	output logic cpu_rst
);

	ctrl_state_e state;
	// Times the CPU reset pulse
	logic [RST_CNT_W-1:0] rst_cnt;
	// Read byte already taken from the RAM
	logic rd_loaded;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_IDLE;
			mon_req <= '0;
			tx_start <= 1'b0;
			tx_data <= '0;
			cpu_halt <= 1'b0;
			cpu_rst <= 1'b0;
			rst_cnt <= '0;
			rd_loaded <= 1'b0;
		end else begin
			// Strobes last one cycle unless set below
			tx_start <= 1'b0;
			mon_req.we <= 1'b0;
			mon_req.re <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (rx_valid) begin
						case (rx_data)
							CMD_HALT: cpu_halt <= 1'b1;
							CMD_RESUME: cpu_halt <= 1'b0;
							CMD_WRITE: state <= ST_WR_ADDR_H;
							CMD_READ: state <= ST_RD_ADDR_H;
							CMD_RESET: begin
								cpu_rst <= 1'b1;
								rst_cnt <= '0;
								state <= ST_RST_HOLD;
							end
							// Unknown opcode, stay idle
							default: state <= ST_IDLE;
						endcase
					end
				end

				// Read path
				ST_RD_ADDR_H: begin
					if (rx_valid) begin
						mon_req.addr[15:8] <= rx_data;
						state <= ST_RD_ADDR_L;
					end
				end

				ST_RD_ADDR_L: begin
					if (rx_valid) begin
						mon_req.addr[7:0] <= rx_data;
						// Read strobe goes out next cycle
						mon_req.re <= 1'b1;
						state <= ST_RD_WAIT;
					end
				end

				ST_RD_WAIT: begin
					// RAM answers at the end of this cycle
					rd_loaded <= 1'b0;
					state <= ST_RD_SEND;
				end

				ST_RD_SEND: begin
					// Take the RAM byte once, on entry
					if (!rd_loaded) begin
						tx_data <= rdata;
						rd_loaded <= 1'b1;
					end
					// Answer only with the CPU held off and the line free
					if (tx_done && cpu_halt) begin
						tx_start <= 1'b1;
						state <= ST_IDLE;
					end else if (!cpu_halt && rx_valid && rx_data == CMD_HALT) begin
						// Halt is still taken so a stalled read can finish
						cpu_halt <= 1'b1;
					end
				end

				// Write path
				ST_WR_ADDR_H: begin
					if (rx_valid) begin
						mon_req.addr[15:8] <= rx_data;
						state <= ST_WR_ADDR_L;
					end
				end

				ST_WR_ADDR_L: begin
					if (rx_valid) begin
						mon_req.addr[7:0] <= rx_data;
						state <= ST_WR_DATA;
					end
				end

				ST_WR_DATA: begin
					if (rx_valid) begin
						mon_req.wdata <= rx_data;
						// Single write strobe, then back to idle
						mon_req.we <= 1'b1;
						state <= ST_IDLE;
					end
				end

				// CPU reset pulse
				ST_RST_HOLD: begin
					if (rst_cnt == RST_CNT_LAST) begin
						cpu_rst <= 1'b0;
						state <= ST_IDLE;
					end else begin
						rst_cnt <= rst_cnt + 1'b1;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read and write never share a bus cycle
	a_no_we_re: assert property (@(posedge clk) disable iff (!rst)
		!(mon_req.we && mon_req.re));

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import dbg_pkg::*; (
	input bus_req_t cpu_req,
	input bus_req_t mon_req,
	input logic cpu_halt,
	input logic cpu_halted,
	output bus_req_t mem_req,
	output logic mon_grant
);

	// Monitor owns the bus only once the CPU has actually stopped
	assign mon_grant = cpu_halt & cpu_halted;

	// Owner drives address, data and strobes
	// Strobes of the other master never reach the RAM
	always_comb begin
		if (mon_grant)
			mem_req = mon_req;
		else
			mem_req = cpu_req;
	end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core import dbg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cpu_halt,
	input logic cpu_rst,
	input logic [7:0] rdata,
	output bus_req_t cpu_req,
	output logic cpu_halted,
	output logic [15:0] pc
);

	// Low is the fetch boundary, high is the increment cycle
	logic phase;
	logic fetch_re;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			phase <= 1'b0;
			fetch_re <= 1'b0;
			cpu_halted <= 1'b0;
		end else if (cpu_rst) begin
			// Held at address zero, no fetches
			pc <= '0;
			phase <= 1'b0;
			fetch_re <= 1'b0;
			cpu_halted <= cpu_halt;
		end else if (!phase) begin
			if (cpu_halt) begin
				// Parked on the boundary
				fetch_re <= 1'b0;
				cpu_halted <= 1'b1;
			end else begin
				cpu_halted <= 1'b0;
				fetch_re <= 1'b1;
				phase <= 1'b1;
			end
		end else begin
			// Byte read, move on
			fetch_re <= 1'b0;
			pc <= pc + 1'b1;
			phase <= 1'b0;
		end
	end

	// Read-only master
	assign cpu_req = '{addr: pc, wdata: 8'h00, we: 1'b0, re: fetch_re};

	// Fetched byte must be defined the cycle after the strobe
	a_fetch_known: assert property (@(posedge clk) disable iff (!rst)
		cpu_req.re && !cpu_halt |=> !$isunknown(rdata));

endmodule

`default_nettype wire

// File: logic/sys_ram.sv
`timescale 1ns/1ns
`default_nettype none

module sys_ram import dbg_pkg::*; (
	input logic clk,
	input bus_req_t mem_req,
	output logic [7:0] rdata
);

	logic [7:0] mem [0:RAM_DEPTH-1];

	// Memory starts cleared
	initial begin
		for (int i = 0; i < RAM_DEPTH; i++) begin
			mem[i] = 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		// Only the low address byte selects a location
		if (mem_req.we)
			mem[mem_req.addr[RAM_AW-1:0]] <= mem_req.wdata;
		// Registered read, holds until the next read strobe
		if (mem_req.re)
			rdata <= mem[mem_req.addr[RAM_AW-1:0]];
	end

endmodule

`default_nettype wire

// File: logic/dbg_top.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_top import dbg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic uart_rxd,
	output logic uart_txd,
	output logic [15:0] cpu_pc
);

	// UART side
	logic rx_valid;
	logic [7:0] rx_data;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_done;

	// Bus side
	bus_req_t cpu_req;
	bus_req_t mon_req;
	bus_req_t mem_req;
	logic [7:0] rdata;
	logic mon_grant;

	// CPU control
	logic cpu_halt;
	logic cpu_rst;
	logic cpu_halted;

	uart_rx u_uart_rx (
		.clk(clk),
		.rst(rst),
		.rxd(uart_rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	uart_tx u_uart_tx (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.txd(uart_txd),
		.tx_done(tx_done)
	);

	sys_ctrl_fsm u_ctrl (
		.clk(clk),
		.rst(rst),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_done(tx_done),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.rdata(rdata),
		.mon_req(mon_req),
		.cpu_halt(cpu_halt),
		.cpu_rst(cpu_rst)
	);

	cpu_core u_cpu (
		.clk(clk),
		.rst(rst),
		.cpu_halt(cpu_halt),
		.cpu_rst(cpu_rst),
		.rdata(rdata),
		.cpu_req(cpu_req),
		.cpu_halted(cpu_halted),
		.pc(cpu_pc)
	);

	bus_arbiter u_arb (
		.cpu_req(cpu_req),
		.mon_req(mon_req),
		.cpu_halt(cpu_halt),
		.cpu_halted(cpu_halted),
		.mem_req(mem_req),
		.mon_grant(mon_grant)
	);

	sys_ram u_ram (
		.clk(clk),
		.mem_req(mem_req),
		.rdata(rdata)
	);

	// A monitor write without grant would be lost at the arbiter
	a_write_granted: assert property (@(posedge clk) disable iff (!rst)
		mon_req.we |-> mon_grant);

	// A granted bus means the CPU has stopped fetching
	a_cpu_quiet: assert property (@(posedge clk) disable iff (!rst)
		mon_grant |-> !cpu_req.re);

endmodule

`default_nettype wire

// File: verif/dbg_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_top_tb import dbg_pkg::*; ();

	// Check applied after a row's bytes are sent
	typedef enum logic [2:0] {
		CHK_NONE,
		CHK_PC_HOLD,
		CHK_READ,
		CHK_PC_RUN,
		CHK_PC_RESET,
		CHK_STALL
	} chk_e;

	// One host command with its expected outcome
	typedef struct packed {
		logic [7:0] cmd;
		logic [1:0] nargs;
		logic [7:0] arg0;
		logic [7:0] arg1;
		logic [7:0] arg2;
		logic [7:0] exp_data;
		chk_e chk;
	} row_t;

	logic clk;
	logic rst;
	logic uart_rxd;
	logic uart_txd;
	logic [15:0] cpu_pc;

	row_t cmd_table[$];
	// Expected RAM contents, low address byte only
	logic [7:0] model [0:255];
	logic written [0:255];
	logic [31:0] rng;
	int val_errs;
	int proto_errs;
	int answers;

	dbg_top UUT (
		.clk(clk),
		.rst(rst),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd),
		.cpu_pc(cpu_pc)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic void add_row(input logic [7:0] cmd, input logic [1:0] nargs,
			input logic [15:0] addr, input logic [7:0] data, input chk_e chk);
		row_t r;
		r = '{cmd: cmd, nargs: nargs, arg0: addr[15:8], arg1: addr[7:0], arg2: data,
			exp_data: model[addr[7:0]], chk: chk};
		cmd_table.push_back(r);
	endfunction

	task automatic build_table();
		logic [15:0] addr;
		logic [7:0] data;
		logic [15:0] wr_addr [0:7];
		for (int i = 0; i < 256; i++) begin
			model[i] = 8'h00;
			written[i] = 1'b0;
		end
		add_row(CMD_HALT, 2'd0, 16'h0000, 8'h00, CHK_PC_HOLD);
		// Random writes, model follows in order
		for (int i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			addr = rng[23:8];
			rng = xorshift(rng);
			data = rng[15:8];
			model[addr[7:0]] = data;
			written[addr[7:0]] = 1'b1;
			wr_addr[i] = addr;
			add_row(CMD_WRITE, 2'd3, addr, data, CHK_NONE);
		end
		for (int i = 0; i < 8; i++) begin
			add_row(CMD_READ, 2'd2, wr_addr[i], 8'h00, CHK_READ);
		end
		// Untouched locations read back as zero
		for (int i = 0; i < 4; i++) begin
			do begin
				rng = xorshift(rng);
				addr = rng[23:8];
			end while (written[addr[7:0]]);
			add_row(CMD_READ, 2'd2, addr, 8'h00, CHK_READ);
		end
		// Unknown opcode, then memory still intact
		add_row(8'h7F, 2'd0, 16'h0000, 8'h00, CHK_NONE);
		add_row(CMD_READ, 2'd2, wr_addr[0], 8'h00, CHK_READ);
		add_row(CMD_RESUME, 2'd0, 16'h0000, 8'h00, CHK_PC_RUN);
		add_row(CMD_RESET, 2'd0, 16'h0000, 8'h00, CHK_PC_RESET);
		// Read with the CPU running stalls until a halt
		add_row(CMD_READ, 2'd2, wr_addr[1], 8'h00, CHK_STALL);
	endtask

	// 8N1 host frame on uart_rxd, LSB first
	task automatic send_byte(input logic [7:0] b);
		logic [FRAME_BITS-1:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge clk);
		for (int i = 0; i < FRAME_BITS; i++) begin
			uart_rxd <= frame[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
		end
	endtask

	task automatic send_cmd(input row_t row);
		send_byte(row.cmd);
		if (row.nargs > 2'd0)
			send_byte(row.arg0);
		if (row.nargs > 2'd1)
			send_byte(row.arg1);
		if (row.nargs > 2'd2)
			send_byte(row.arg2);
	endtask

	// Waits up to max_wait cycles for a start bit, then samples mid-bit
	task automatic receive_byte(input int max_wait, output logic got, output logic [7:0] data);
		int waited;
		got = 1'b0;
		data = 8'h00;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (uart_txd && waited < max_wait);
		if (!uart_txd) begin
			got = 1'b1;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				data[i] = uart_txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (uart_txd) else begin
				$display("UART answer has no stop bit at %0t ns", $time);
				proto_errs++;
			end
		end
	endtask

	task automatic apply_row(input row_t row);
		logic got;
		logic [7:0] data;
		logic [15:0] pc_ref;
		int waited;
		int bad;
		got = 1'b0;
		data = 8'h00;
		waited = 0;
		bad = 0;
		case (row.chk)
			CHK_PC_HOLD: begin
				send_cmd(row);
				// Halt lands within two cycles, give it margin
				repeat (2 * CLKS_PER_BIT) @(negedge clk);
				pc_ref = cpu_pc;
				for (int i = 0; i < 50; i++) begin
					@(negedge clk);
					if (cpu_pc != pc_ref)
						bad++;
				end
				assert (bad == 0) else begin
					$display("[ERROR] %0t ns: pc moved off %h in %0d halted cycles",
						$time, pc_ref, bad);
					val_errs++;
				end
			end
			CHK_READ: begin
				fork
					send_cmd(row);
					receive_byte(4 * FRAME_BITS * CLKS_PER_BIT, got, data);
				join
				assert (got) else begin
					$display("No UART answer to the read of %h%h", row.arg0, row.arg1);
					proto_errs++;
				end
				if (got) begin
					answers++;
					assert (data == row.exp_data) else begin
						$display("[ERROR] %0t ns: read %h%h gave %h, expected %h",
							$time, row.arg0, row.arg1, data, row.exp_data);
						val_errs++;
					end
				end
			end
			CHK_PC_RUN: begin
				send_cmd(row);
				pc_ref = cpu_pc;
				do begin
					@(negedge clk);
					waited++;
				end while (cpu_pc <= pc_ref && waited < 100);
				assert (cpu_pc > pc_ref) else begin
					$display("CPU pc did not advance after resume");
					proto_errs++;
				end
			end
			CHK_PC_RESET: begin
				send_cmd(row);
				do begin
					@(negedge clk);
					waited++;
				end while (cpu_pc != 16'h0000 && waited < 32);
				assert (cpu_pc == 16'h0000) else begin
					$display("CPU pc did not return to zero after the reset command");
					proto_errs++;
				end
				// Still inside the reset pulse
				for (int i = 0; i < 200; i++) begin
					@(negedge clk);
					if (cpu_pc != 16'h0000)
						bad++;
				end
				assert (bad == 0) else begin
					$display("[ERROR] %0t ns: pc left zero in %0d reset cycles", $time, bad);
					val_errs++;
				end
				waited = 0;
				do begin
					@(negedge clk);
					waited++;
				end while (cpu_pc == 16'h0000 && waited < 2 * RST_HOLD_CYCLES);
				assert (cpu_pc != 16'h0000) else begin
					$display("CPU pc stayed at zero after the reset pulse");
					proto_errs++;
				end
			end
			CHK_STALL: begin
				fork
					send_cmd(row);
					receive_byte(4 * FRAME_BITS * CLKS_PER_BIT, got, data);
				join
				assert (!got) else begin
					$display("Read was answered while the CPU was running");
					proto_errs++;
				end
				// Halt releases the pending answer, its value is not meaningful
				fork
					send_byte(CMD_HALT);
					receive_byte(4 * FRAME_BITS * CLKS_PER_BIT, got, data);
				join
				assert (got) else begin
					$display("Stalled read was never answered after the halt");
					proto_errs++;
				end
				if (got)
					answers++;
			end
			default: begin
				send_cmd(row);
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		uart_rxd = 1'b1;
		rng = 32'd91;
		val_errs = 0;
		proto_errs = 0;
		answers = 0;
		build_table();
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		foreach (cmd_table[i]) begin
			apply_row(cmd_table[i]);
		end
		$display("Errors: %0d value, %0d protocol or timeout; %0d answers received",
			val_errs, proto_errs, answers);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dbg_monitor.f
logic/dbg_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/sys_ctrl_fsm.sv
logic/bus_arbiter.sv
logic/cpu_core.sv
logic/sys_ram.sv
logic/dbg_top.sv
verif/dbg_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dbg_top_tb \
	-f dbg_monitor.f -o dbg_top_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/dbg_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result comes from the log
if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0
